// ==== filelist.f ====
+incdir+hdl
+incdir+bench
hdl/thermal_pkg.sv
hdl/credit_fifo.sv
hdl/pixel_pair_decoder.sv
hdl/int16_to_float.sv
hdl/frame_writer.sv
hdl/thermal_frame_top.sv
bench/thermal_frame_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= thermal_frame_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/frame_vectors.svh ====
// Corner case int16 samples paired with their exact single precision patterns
`ifndef FRAME_VECTORS_SVH
`define FRAME_VECTORS_SVH

// --------------------
// Corner table
// --------------------

// Row i of both arrays forms one entry, the int16 sample and its float bits
localparam int NUM_VECTORS = 7;

localparam logic [15:0] VEC_SAMPLE [NUM_VECTORS] = '{
    16'h0000,   // 0
    16'h0001,   // 1
    16'hFFFF,   // -1
    16'h7FFF,   // 32767, largest positive
    16'h8000,   // -32768, magnitude has no positive twin
    16'h0100,   // 256
    16'hFFFD    // -3
};

localparam logic [31:0] VEC_FLOAT [NUM_VECTORS] = '{
    // Zero stays all zero bits
    32'h0000_0000,
    32'h3F80_0000,
    32'hBF80_0000,
    // Fourteen mantissa ones after the hidden bit
    32'h46FF_FE00,
    // Exact power of two, exponent 15
    32'hC700_0000,
    32'h4380_0000,
    32'hC040_0000
};

`endif

// ==== bench/thermal_frame_tb.sv ====
// Testbench for the thermal frame path with credit flow, back-pressure and readback
`timescale 1ns/100ps
`include "thermal_settings.svh"

module thermal_frame_tb import thermal_pkg::*; ();

    `include "frame_vectors.svh"

    localparam int NUM_FRAMES = 2;
    // Eight cycles per pixel and frame, doubled to cover readback
    localparam int WATCHDOG_CYCLES = NUM_FRAMES * `FRAME_PIXELS * 8 * 2;

    logic        clk;
    logic        reset;
    raw_byte_t   in_byte;
    logic        in_valid;
    frame_addr_t rd_addr;
    logic        in_credit;
    logic        frame_ready;
    raw_byte_t   rd_data;

    // Current frame stimulus and expected floats
    pixel_t frame_samples [`FRAME_PIXELS];
    float_t frame_expect  [`FRAME_PIXELS];

    logic [31:0] lcg_state;
    int          bytes_sent;
    int          bytes_seen;
    int          credits_back;
    int          stall_cycles;
    int          check_count;
    int          error_count;
    int          test_errors;

    thermal_frame_top thermal_frame_top_inst (
        .clk(clk), .reset(reset),
        .in_byte(in_byte), .in_valid(in_valid), .rd_addr(rd_addr),
        .in_credit(in_credit), .frame_ready(frame_ready), .rd_data(rd_data)
    );

    always #2 clk = ~clk;

    // --------------------
    // Helpers
    // --------------------
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Exact float, hidden one at the top set bit of the magnitude
    function automatic float_t int16_to_single(input pixel_t value);
        int          magnitude;
        int          exponent;
        logic [22:0] mantissa;
        magnitude = (value < 0) ? -int'(value) : int'(value);
        if (magnitude == 0) begin
            return '0;
        end
        exponent = 0;
        while ((magnitude >> (exponent + 1)) != 0) begin
            exponent++;
        end
        mantissa = 23'((magnitude - (1 << exponent)) << (23 - exponent));
        return {value[15], 8'(127 + exponent), mantissa};
    endfunction

    // Source credits left, returns are counted mid cycle
    function automatic int credits_available();
        return `IN_CREDITS - bytes_sent + credits_back;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, actual, expected);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        if (error_count == test_errors) begin
            $display("test %s PASS", name);
        end else begin
            $display("test %s FAIL with %0d errors", name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    // Random fill, then the corner table at table_base
    task automatic build_frame(input int table_base);
        for (int p = 0; p < `FRAME_PIXELS; p++) begin
            lcg_state        = lcg_next(lcg_state);
            frame_samples[p] = pixel_t'(lcg_state[31:16]);
            frame_expect[p]  = int16_to_single(frame_samples[p]);
        end
        for (int i = 0; i < NUM_VECTORS; i++) begin
            frame_samples[table_base + i] = pixel_t'(VEC_SAMPLE[i]);
            frame_expect[table_base + i]  = VEC_FLOAT[i];
        end
    endtask

    // --------------------
    // Byte source
    // --------------------
    task automatic send_frame(input bit with_gaps);
        int        gap;
        raw_byte_t next_byte;
        for (int n = 0; n < 2 * `FRAME_PIXELS; n++) begin
            // MSB of each pixel goes first
            next_byte = n[0] ? frame_samples[n / 2][7:0] : frame_samples[n / 2][15:8];
            gap = 0;
            if (with_gaps) begin
                lcg_state = lcg_next(lcg_state);
                // Half back to back, the rest idle up to three cycles
                gap = lcg_state[20] ? int'(lcg_state[19:18]) : 0;
            end
            repeat (gap) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
            @(posedge clk);
            // Hold off until a credit is back
            while (credits_available() == 0) begin
                in_valid <= 1'b0;
                stall_cycles++;
                @(posedge clk);
            end
            in_valid <= 1'b1;
            in_byte  <= next_byte;
            bytes_sent++;
        end
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic wait_frame_ready();
        int waited;
        waited = 0;
        while (!frame_ready && waited < `FRAME_PIXELS * 8) begin
            @(negedge clk);
            waited++;
        end
        if (!frame_ready) begin
            $display("frame_ready did not rise after the whole frame was sent");
            error_count++;
        end
    endtask

    // One byte per cycle, data lags the address by one cycle
    task automatic read_frame();
        float_t word;
        int     idx;
        word = '0;
        for (int i = 0; i <= `FRAME_BYTES; i++) begin
            @(posedge clk);
            if (i < `FRAME_BYTES) begin
                rd_addr <= frame_addr_t'(i);
            end
            @(negedge clk);
            if (i > 0) begin
                idx  = i - 1;
                word = {word[23:0], rd_data};
                if (idx % 4 == 3) begin
                    check_value($sformatf("rd_data pixel %0d", idx / 4), word,
                                frame_expect[idx / 4]);
                end
            end
        end
    endtask

    task automatic watch_frame_drop();
        int base;
        int waited;
        base = bytes_sent;
        check_value("frame_ready", 32'(frame_ready), 32'd1);
        while (bytes_sent == base) begin
            @(posedge clk);
        end
        waited = 0;
        while (frame_ready && waited < 16) begin
            @(negedge clk);
            waited++;
        end
        if (frame_ready) begin
            $display("frame_ready stayed high after the next frame began");
            error_count++;
        end
    endtask

    // --------------------
    // Credit monitor
    // --------------------
    always @(negedge clk) begin
        if (!reset) begin
            if (in_valid) begin
                bytes_seen++;
            end
            if (in_credit) begin
                credits_back++;
            end
            if (credits_back > bytes_seen) begin
                $display("credit returned at %0t for a byte never sent", $time);
                error_count++;
            end
        end
    end

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        in_valid     = 1'b0;
        in_byte      = '0;
        rd_addr      = '0;
        lcg_state    = 32'd54443;
        bytes_sent   = 0;
        bytes_seen   = 0;
        credits_back = 0;
        stall_cycles = 0;
        check_count  = 0;
        error_count  = 0;
        test_errors  = 0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset, nothing should move
        repeat (8) @(negedge clk);
        check_value("frame_ready", 32'(frame_ready), 32'd0);
        check_value("credits_back", credits_back, 0);
        finish_test("reset idle");

        // First frame with random gaps and bursts
        build_frame(0);
        send_frame(1'b1);
        wait_frame_ready();
        read_frame();
        finish_test("frame readback");

        check_value("credits_back", credits_back, bytes_sent);
        finish_test("credit conservation");

        // Second frame at full credit rate, writer is the bottleneck
        stall_cycles = 0;
        build_frame(`FRAME_PIXELS - NUM_VECTORS);
        fork
            send_frame(1'b0);
            watch_frame_drop();
        join
        finish_test("frame_ready drop");

        if (stall_cycles == 0) begin
            $display("credits never ran out while sending at full rate");
            error_count++;
        end
        wait_frame_ready();
        read_frame();
        check_value("credits_back", credits_back, bytes_sent);
        finish_test("back-pressure second frame");

        $display("checks %0d errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== hdl/thermal_frame_top.sv ====
// Thermal frame front end top joining FIFOs, decoder, converter and writer
`timescale 1ns/100ps
`include "thermal_settings.svh"

module thermal_frame_top import thermal_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  raw_byte_t   in_byte,
    input  logic        in_valid,
    input  frame_addr_t rd_addr,
    output logic        in_credit,
    output logic        frame_ready,
    output raw_byte_t   rd_data
);

    // Raw FIFO to decoder
    raw_byte_t raw_head;
    logic      raw_empty;
    logic      raw_pop;

    // Decoder to converter
    pixel_t sample;
    logic   sample_valid;
    logic   frame_start;

    // Converter to float FIFO and back
    float_t float_value;
    logic   float_valid;
    float_t float_head;
    logic   float_empty;
    logic   float_pop;
    logic   float_credit;

    // --------------------
    // Decode
    // --------------------
    credit_fifo #(.item_t(raw_byte_t), .DEPTH(`IN_CREDITS)) raw_fifo_inst (
        .clk(clk), .reset(reset),
        .push(in_valid), .push_data(in_byte), .pop(raw_pop),
        .head(raw_head), .empty(raw_empty), .credit(in_credit)
    );

    pixel_pair_decoder pixel_pair_decoder_inst (
        .clk(clk), .reset(reset),
        .raw_head(raw_head), .raw_empty(raw_empty), .float_credit(float_credit),
        .raw_pop(raw_pop), .sample(sample), .sample_valid(sample_valid),
        .frame_start(frame_start)
    );

    // --------------------
    // Execute
    // --------------------
    int16_to_float int16_to_float_inst (
        .clk(clk), .reset(reset),
        .sample(sample), .sample_valid(sample_valid),
        .float_value(float_value), .float_valid(float_valid)
    );

    // --------------------
    // Result
    // --------------------
    credit_fifo #(.item_t(float_t), .DEPTH(`FLOAT_CREDITS)) float_fifo_inst (
        .clk(clk), .reset(reset),
        .push(float_valid), .push_data(float_value), .pop(float_pop),
        .head(float_head), .empty(float_empty), .credit(float_credit)
    );

    frame_writer frame_writer_inst (
        .clk(clk), .reset(reset),
        .float_head(float_head), .float_empty(float_empty),
        .frame_start(frame_start), .rd_addr(rd_addr),
        .float_pop(float_pop), .frame_ready(frame_ready), .rd_data(rd_data)
    );

endmodule

// ==== hdl/frame_writer.sv ====
// Frame writer storing floats MSB first in the frame buffer with a read port
`timescale 1ns/100ps
`include "thermal_settings.svh"

module frame_writer import thermal_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  float_t      float_head,
    input  logic        float_empty,
    input  logic        frame_start,
    input  frame_addr_t rd_addr,
    output logic        float_pop,
    output logic        frame_ready,
    output raw_byte_t   rd_data
);

    // Frame buffer, four bytes per pixel
    raw_byte_t frame_mem [`FRAME_BYTES];

    // Byte phase, zero means idle and ready for the next float
    logic [1:0]  phase;
    float_t      float_reg;
    frame_addr_t wr_addr;

    logic      wr_en;
    raw_byte_t wr_byte;
    logic      last_byte;

    // Pop writes the MSB straight from the FIFO head
    assign float_pop = (phase == 2'd0) && !float_empty;
    assign wr_en     = float_pop || (phase != 2'd0);
    assign last_byte = wr_en && (wr_addr == frame_addr_t'(`FRAME_BYTES - 1));

    // Byte select, most significant first
    always_comb begin
        case (phase)
            2'd0:    wr_byte = float_head[31:24];
            2'd1:    wr_byte = float_reg[23:16];
            2'd2:    wr_byte = float_reg[15:8];
            default: wr_byte = float_reg[7:0];
        endcase
    end

    // --------------------
    // Buffer write and read
    // --------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            frame_mem[wr_addr] <= wr_byte;
        end
        // Host read, registered every cycle
        rd_data <= frame_mem[rd_addr];
        if (float_pop) begin
            float_reg <= float_head;
        end
    end

    // --------------------
    // Address, phase, ready
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= 2'd0;
            wr_addr     <= '0;
            frame_ready <= 1'b0;
        end else begin
            if (wr_en) begin
                phase   <= phase + 2'd1;
                wr_addr <= last_byte ? '0 : wr_addr + 1'b1;
            end
            // New frame accepted takes the flag down
            if (frame_start) begin
                frame_ready <= 1'b0;
            end else if (last_byte) begin
                frame_ready <= 1'b1;
            end
        end
    end

endmodule

// ==== hdl/int16_to_float.sv ====
// Three-stage pipeline converting signed int16 samples to single precision
`timescale 1ns/100ps

module int16_to_float import thermal_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  pixel_t sample,
    input  logic   sample_valid,
    output float_t float_value,
    output logic   float_valid
);

    // Exponent bias plus position of the top magnitude bit
    localparam logic [7:0] EXP_BASE = 8'd142;

    // Valid bits shifting alongside the data
    logic [2:0] valid_pipe;

    // Stage 1 registers
    logic        s1_sign;
    logic [15:0] s1_mag;

    // Stage 2 registers
    logic        s2_sign;
    logic [15:0] s2_mag;
    logic [4:0]  s2_lz;

    // Stage 3 combinational shift
    logic [15:0] norm_mag;

    // Index of highest set bit decides the count, 16 for zero
    function automatic logic [4:0] count_leading_zeros(input logic [15:0] value);
        logic [4:0] count;
        count = 5'd16;
        for (int i = 0; i < 16; i++) begin
            if (value[i]) begin
                count = 5'(15 - i);
            end
        end
        return count;
    endfunction

    assign norm_mag = s2_mag << s2_lz;

    // --------------------
    // Stage 1 sign/magnitude
    // --------------------
    always_ff @(posedge clk) begin
        s1_sign <= sample[15];
        // -32768 wraps to 16'h8000 which is the right unsigned magnitude
        s1_mag  <= sample[15] ? 16'(-sample) : 16'(sample);
    end

    // --------------------
    // Stage 2 leading zeros
    // --------------------
    always_ff @(posedge clk) begin
        s2_sign <= s1_sign;
        s2_mag  <= s1_mag;
        s2_lz   <= count_leading_zeros(s1_mag);
    end

    // --------------------
    // Stage 3 normalise and pack
    // --------------------
    always_ff @(posedge clk) begin
        if (s2_mag == '0) begin
            // Zero is all zero bits, never negative zero
            float_value <= '0;
        end else begin
            // Hidden one dropped, 15 bits fit the mantissa exactly
            float_value <= {s2_sign,
                            EXP_BASE - 8'(s2_lz),
                            norm_mag[14:0],
                            8'h00};
        end
    end

    // Valid shift
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[1:0], sample_valid};
        end
    end

    assign float_valid = valid_pipe[2];

endmodule

// ==== hdl/pixel_pair_decoder.sv ====
// Pixel pair decoder joining big-endian byte pairs into signed samples
`timescale 1ns/100ps
`include "thermal_settings.svh"

module pixel_pair_decoder import thermal_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  raw_byte_t raw_head,
    input  logic      raw_empty,
    input  logic      float_credit,
    output logic      raw_pop,
    output pixel_t    sample,
    output logic      sample_valid,
    output logic      frame_start
);

    localparam int CREDIT_W = $clog2(`FLOAT_CREDITS + 1);
    localparam int PIXEL_W  = $clog2(`FRAME_PIXELS);

    raw_byte_t           msb_reg;
    logic                lsb_phase;
    logic [CREDIT_W-1:0] credits;
    logic [PIXEL_W-1:0]  pixel_cnt;

    // Sample issue, which also spends one float credit
    logic issue;

    // MSB goes freely, LSB waits for room downstream
    assign raw_pop     = !raw_empty && (!lsb_phase || (credits != '0));
    assign issue       = raw_pop && lsb_phase;
    assign frame_start = raw_pop && !lsb_phase && (pixel_cnt == '0);

    // --------------------
    // Byte assembly
    // --------------------
    always_ff @(posedge clk) begin
        if (raw_pop && !lsb_phase) begin
            msb_reg <= raw_head;
        end
        if (issue) begin
            sample <= pixel_t'({msb_reg, raw_head});
        end
    end

    // --------------------
    // Control and credits
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            lsb_phase    <= 1'b0;
            credits      <= CREDIT_W'(`FLOAT_CREDITS);
            pixel_cnt    <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= issue;
            if (raw_pop) begin
                lsb_phase <= !lsb_phase;
            end
            // Spend on issue, refill on each float FIFO pop
            credits <= credits + CREDIT_W'(float_credit) - CREDIT_W'(issue);
            if (issue) begin
                pixel_cnt <= (pixel_cnt == PIXEL_W'(`FRAME_PIXELS - 1)) ?
                             '0 : pixel_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== hdl/credit_fifo.sv ====
// Credit-managed FIFO that returns one credit pulse per popped entry
`timescale 1ns/100ps

module credit_fifo #(
    parameter type item_t = logic [7:0],
    parameter int  DEPTH  = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  push,
    input  item_t push_data,
    input  logic  pop,
    output item_t head,
    output logic  empty,
    output logic  credit
);

    // Pointer and occupancy widths
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // Storage, no reset needed on payload
    item_t storage [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // A pop only counts when something is there
    logic do_pop;

    assign do_pop = pop && !empty;
    assign empty  = (count == '0);
    assign head   = storage[rd_ptr];

    // Sender gets one slot back for every entry leaving
    assign credit = do_pop;

    // --------------------
    // Payload write
    // --------------------
    always_ff @(posedge clk) begin
        if (push) begin
            storage[wr_ptr] <= push_data;
        end
    end

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Explicit wrap so non power of two depths work
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(do_pop);
        end
    end

endmodule

// ==== hdl/thermal_pkg.sv ====
// Shared data types for the thermal pixel path
`include "thermal_settings.svh"

package thermal_pkg;

    // --------------------
    // Pixel data
    // --------------------

    // One raw byte as it arrives from the sensor
    typedef logic [7:0] raw_byte_t;

    // Assembled signed sample, big-endian on the wire
    typedef logic signed [15:0] pixel_t;

    // IEEE-754 single precision bit pattern
    typedef logic [31:0] float_t;

    // --------------------
    // Frame buffer
    // --------------------

    // Byte address covering four bytes per pixel
    typedef logic [$clog2(`FRAME_BYTES)-1:0] frame_addr_t;

endpackage

// ==== hdl/thermal_settings.svh ====
// Thermal frame front end settings for frame geometry and credit depths
`ifndef THERMAL_SETTINGS_SVH
`define THERMAL_SETTINGS_SVH

// --------------------
// Frame geometry
// --------------------

// Pixels per camera frame, 32 x 24 sensor
`define FRAME_PIXELS 768

// Each pixel is stored as a four byte float
`define FRAME_BYTES (4 * `FRAME_PIXELS)

// --------------------
// Flow control
// --------------------

// Credits the byte source holds after reset, also the raw FIFO depth
`define IN_CREDITS 4

// Float FIFO depth and decoder credit count for that FIFO
`define FLOAT_CREDITS 4

`endif
